// File: Makefile
VERILATOR = verilator
LINTFLAGS = --lint-only -Wall --timing
SIMFLAGS = --binary --timing -Wno-fatal
TOP = rsTb
FILELIST = compile.f
PASSMSG = === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf obj_dir

// File: compile.f
rsPkg.sv
rsAlloc.sv
rsOperandArray.sv
rsPayloadArray.sv
rsIssueSelect.sv
reservationStation.sv
rsTb.sv

// File: reservationStation.sv
`timescale 1ns/1ps

module reservationStation #(
  parameter int EntryCount = rsPkg::EntryCount
) (
  input  logic clk,
  input  logic rstN,
  input  rsPkg::dispatchT dispatch,
  input  rsPkg::bcastT [rsPkg::BcastCount-1:0] bcast,
  input  logic [rsPkg::PortCount-1:0] pause,
  output rsPkg::issueT [rsPkg::PortCount-1:0] issue,
  output logic doStall
);

  logic [EntryCount-1:0] allocSel;
  logic [EntryCount-1:0] entryValid;
  logic [EntryCount-1:0] readyA;
  logic [EntryCount-1:0] readyB;
  logic [EntryCount-1:0] entryPort;
  logic [rsPkg::PortCount-1:0][EntryCount-1:0] issueSel;
  logic [rsPkg::PortCount-1:0][rsPkg::DataWidth-1:0] readDataA;
  logic [rsPkg::PortCount-1:0][rsPkg::DataWidth-1:0] readDataB;
  logic [rsPkg::PortCount-1:0][rsPkg::TagWidth-1:0] readDest;
  logic [rsPkg::PortCount-1:0][rsPkg::OpWidth-1:0] readOp;
  logic [rsPkg::PortCount-1:0][rsPkg::IiWidth-1:0] readIi;

  rsAlloc #(.EntryCount(EntryCount)) u_alloc (
    .clk        (clk),
    .rstN       (rstN),
    .dispVld    (dispatch.vld),
    .issueSel   (issueSel),
    .allocSel   (allocSel),
    .entryValid (entryValid),
    .doStall    (doStall)
  );

  rsOperandArray #(.EntryCount(EntryCount)) u_opA (
    .clk        (clk),
    .rstN       (rstN),
    .allocSel   (allocSel),
    .src        (dispatch.srcA),
    .bcast      (bcast),
    .entryValid (entryValid),
    .readSel    (issueSel),
    .ready      (readyA),
    .readData   (readDataA)
  );

  rsOperandArray #(.EntryCount(EntryCount)) u_opB (
    .clk        (clk),
    .rstN       (rstN),
    .allocSel   (allocSel),
    .src        (dispatch.srcB),
    .bcast      (bcast),
    .entryValid (entryValid),
    .readSel    (issueSel),
    .ready      (readyB),
    .readData   (readDataB)
  );

  rsPayloadArray #(.EntryCount(EntryCount)) u_payload (
    .clk       (clk),
    .rstN      (rstN),
    .allocSel  (allocSel),
    .dispatch  (dispatch),
    .readSel   (issueSel),
    .entryPort (entryPort),
    .readDest  (readDest),
    .readOp    (readOp),
    .readIi    (readIi)
  );

  rsIssueSelect #(.EntryCount(EntryCount)) u_select (
    .clk        (clk),
    .rstN       (rstN),
    .entryValid (entryValid),
    .readyA     (readyA),
    .readyB     (readyB),
    .entryPort  (entryPort),
    .pause      (pause),
    .readDataA  (readDataA),
    .readDataB  (readDataB),
    .readDest   (readDest),
    .readOp     (readOp),
    .readIi     (readIi),
    .issueSel   (issueSel),
    .issue      (issue)
  );

endmodule

// File: rsAlloc.sv
`timescale 1ns/1ps

module rsAlloc #(
  parameter int EntryCount = rsPkg::EntryCount
) (
  input  logic clk,
  input  logic rstN,
  input  logic dispVld,
  input  logic [rsPkg::PortCount-1:0][EntryCount-1:0] issueSel,
  output logic [EntryCount-1:0] allocSel,
  output logic [EntryCount-1:0] entryValid,
  output logic doStall
);

  logic [EntryCount-1:0] freeVec;
  logic [EntryCount-1:0] lowestFree;
  logic [EntryCount-1:0] issuedVec;

  // isolate the lowest set bit of the free vector
  assign freeVec = ~entryValid;
  assign lowestFree = freeVec & (~freeVec + 1'b1);
  assign allocSel = dispVld ? lowestFree : '0;

  // full station means no free bit, so allocSel is empty too
  assign doStall = &entryValid;

  always_comb begin
    issuedVec = '0;
    for (int p = 0; p < rsPkg::PortCount; p++) begin
      issuedVec = issuedVec | issueSel[p];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      entryValid <= '0;
    end else begin
      entryValid <= (entryValid | allocSel) & ~issuedVec;
    end
  end

endmodule

// File: rsIssueSelect.sv
`timescale 1ns/1ps

module rsIssueSelect #(
  parameter int EntryCount = rsPkg::EntryCount
) (
  input  logic clk,
  input  logic rstN,
  input  logic [EntryCount-1:0] entryValid,
  input  logic [EntryCount-1:0] readyA,
  input  logic [EntryCount-1:0] readyB,
  input  logic [EntryCount-1:0] entryPort,
  input  logic [rsPkg::PortCount-1:0] pause,
  input  logic [rsPkg::PortCount-1:0][rsPkg::DataWidth-1:0] readDataA,
  input  logic [rsPkg::PortCount-1:0][rsPkg::DataWidth-1:0] readDataB,
  input  logic [rsPkg::PortCount-1:0][rsPkg::TagWidth-1:0] readDest,
  input  logic [rsPkg::PortCount-1:0][rsPkg::OpWidth-1:0] readOp,
  input  logic [rsPkg::PortCount-1:0][rsPkg::IiWidth-1:0] readIi,
  output logic [rsPkg::PortCount-1:0][EntryCount-1:0] issueSel,
  output rsPkg::issueT [rsPkg::PortCount-1:0] issue
);

  logic [rsPkg::PortCount-1:0][EntryCount-1:0] cand;
  logic [rsPkg::PortCount-1:0][EntryCount-1:0] pick;

  // each entry competes only on its bound port, lowest index wins
  always_comb begin
    for (int p = 0; p < rsPkg::PortCount; p++) begin
      for (int i = 0; i < EntryCount; i++) begin
        cand[p][i] = entryValid[i] & readyA[i] & readyB[i] & (int'(entryPort[i]) == p);
      end
      pick[p] = cand[p] & (~cand[p] + 1'b1);
      issueSel[p] = pause[p] ? '0 : pick[p];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      issue <= '0;
    end else begin
      for (int p = 0; p < rsPkg::PortCount; p++) begin
        issue[p].vld <= |issueSel[p];
        issue[p].dataA <= readDataA[p];
        issue[p].dataB <= readDataB[p];
        issue[p].dest <= readDest[p];
        issue[p].op <= readOp[p];
        issue[p].ii <= readIi[p];
      end
    end
  end

endmodule

// File: rsOperandArray.sv
`timescale 1ns/1ps

module rsOperandArray #(
  parameter int EntryCount = rsPkg::EntryCount
) (
  input  logic clk,
  input  logic rstN,
  input  logic [EntryCount-1:0] allocSel,
  input  rsPkg::srcT src,
  input  rsPkg::bcastT [rsPkg::BcastCount-1:0] bcast,
  input  logic [EntryCount-1:0] entryValid,
  input  logic [rsPkg::PortCount-1:0][EntryCount-1:0] readSel,
  output logic [EntryCount-1:0] ready,
  output logic [rsPkg::PortCount-1:0][rsPkg::DataWidth-1:0] readData
);

  logic [rsPkg::TagWidth-1:0] tag [EntryCount];
  logic [rsPkg::DataWidth-1:0] value [EntryCount];
  logic [EntryCount-1:0] wake;
  logic [rsPkg::DataWidth-1:0] wakeVal [EntryCount];
  logic srcHit;
  logic [rsPkg::DataWidth-1:0] srcHitVal;

  // same-cycle bypass for the operand being dispatched
  always_comb begin
    srcHit = 1'b0;
    srcHitVal = src.value;
    for (int b = 0; b < rsPkg::BcastCount; b++) begin
      if (bcast[b].vld && bcast[b].tag == src.tag) begin
        srcHit = 1'b1;
        srcHitVal = bcast[b].value;
      end
    end
  end

  // tag match against every bus, only for entries still waiting
  always_comb begin
    for (int i = 0; i < EntryCount; i++) begin
      wake[i] = 1'b0;
      wakeVal[i] = value[i];
      for (int b = 0; b < rsPkg::BcastCount; b++) begin
        if (bcast[b].vld && bcast[b].tag == tag[i]) begin
          wake[i] = 1'b1;
          wakeVal[i] = bcast[b].value;
        end
      end
      wake[i] = wake[i] & entryValid[i] & ~ready[i];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ready <= '0;
    end else begin
      for (int i = 0; i < EntryCount; i++) begin
        if (allocSel[i]) begin
          ready[i] <= src.rdy | srcHit;
        end else if (wake[i]) begin
          ready[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < EntryCount; i++) begin
      if (allocSel[i]) begin
        tag[i] <= src.tag;
        value[i] <= src.rdy ? src.value : srcHitVal;
      end else if (wake[i]) begin
        value[i] <= wakeVal[i];
      end
    end
  end

  // readSel is one-hot per port
  always_comb begin
    readData = '0;
    for (int p = 0; p < rsPkg::PortCount; p++) begin
      for (int i = 0; i < EntryCount; i++) begin
        if (readSel[p][i]) begin
          readData[p] = value[i];
        end
      end
    end
  end

endmodule

// File: rsPayloadArray.sv
`timescale 1ns/1ps

module rsPayloadArray #(
  parameter int EntryCount = rsPkg::EntryCount
) (
  input  logic clk,
  input  logic rstN,
  input  logic [EntryCount-1:0] allocSel,
  input  rsPkg::dispatchT dispatch,
  input  logic [rsPkg::PortCount-1:0][EntryCount-1:0] readSel,
  output logic [EntryCount-1:0] entryPort,
  output logic [rsPkg::PortCount-1:0][rsPkg::TagWidth-1:0] readDest,
  output logic [rsPkg::PortCount-1:0][rsPkg::OpWidth-1:0] readOp,
  output logic [rsPkg::PortCount-1:0][rsPkg::IiWidth-1:0] readIi
);

  logic [rsPkg::TagWidth-1:0] dest [EntryCount];
  logic [rsPkg::OpWidth-1:0] op [EntryCount];
  logic [rsPkg::IiWidth-1:0] ii [EntryCount];

  // port binding steers the selector
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      entryPort <= '0;
    end else begin
      for (int i = 0; i < EntryCount; i++) begin
        if (allocSel[i]) begin
          entryPort[i] <= dispatch.port;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < EntryCount; i++) begin
      if (allocSel[i]) begin
        dest[i] <= dispatch.dest;
        op[i] <= dispatch.op;
        ii[i] <= dispatch.ii;
      end
    end
  end

  always_comb begin
    readDest = '0;
    readOp = '0;
    readIi = '0;
    for (int p = 0; p < rsPkg::PortCount; p++) begin
      for (int i = 0; i < EntryCount; i++) begin
        if (readSel[p][i]) begin
          readDest[p] = dest[i];
          readOp[p] = op[i];
          readIi[p] = ii[i];
        end
      end
    end
  end

endmodule

// File: rsPkg.sv
package rsPkg;

  // 8 entries
  localparam int EntryIdxWidth = 3;
  localparam int EntryCount = 2 ** EntryIdxWidth;

  localparam int DataWidth = 32;
  localparam int TagWidth = 6;
  localparam int OpWidth = 8;
  localparam int IiWidth = 10;
  localparam int PortCount = 2;
  localparam int BcastCount = 3;

  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic rdy;
    logic [DataWidth-1:0] value;
  } srcT;

  // port selects one of the two issue ports
  typedef struct packed {
    logic vld;
    srcT srcA;
    srcT srcB;
    logic [TagWidth-1:0] dest;
    logic [OpWidth-1:0] op;
    logic [IiWidth-1:0] ii;
    logic port;
  } dispatchT;

  typedef struct packed {
    logic vld;
    logic [TagWidth-1:0] tag;
    logic [DataWidth-1:0] value;
  } bcastT;

  typedef struct packed {
    logic vld;
    logic [DataWidth-1:0] dataA;
    logic [DataWidth-1:0] dataB;
    logic [TagWidth-1:0] dest;
    logic [OpWidth-1:0] op;
    logic [IiWidth-1:0] ii;
  } issueT;

endpackage

// File: rsTb.sv
`timescale 1ns/1ps

module rsTb;

  localparam int RandDisp = 200;
  localparam int BurstDisp = 12;
  localparam int TotalDisp = RandDisp + BurstDisp;
  localparam int TimeoutCycles = 4 * TotalDisp + 200;
  localparam int MaxPending = 40;

  logic clk = 1'b0;
  logic rstN;
  rsPkg::dispatchT dispatch;
  rsPkg::bcastT [rsPkg::BcastCount-1:0] bcast;
  logic [rsPkg::PortCount-1:0] pause;
  rsPkg::issueT [rsPkg::PortCount-1:0] issue;
  logic doStall;

  // model state per instruction index is 1 waiting, 2 issued or 3 dropped at a stall
  rsPkg::dispatchT mDisp [TotalDisp];
  int mState [TotalDisp];
  int mReadyCyc [TotalDisp];
  logic [rsPkg::TagWidth-1:0] pendTag [$];
  logic [rsPkg::TagWidth-1:0] nextTag;
  int cycCount, cyc, presented, inFlight, issuedCnt;
  int errCount, checkCount, testCount, dispLimit, dispRate, pauseRate;
  bit sawStall;
  string testName;

  reservationStation #(.EntryCount(rsPkg::EntryCount)) u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .dispatch (dispatch),
    .bcast    (bcast),
    .pause    (pause),
    .issue    (issue),
    .doStall  (doStall)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycCount++;
    if (cycCount > TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic checkVal(input string what, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    checkCount++;
    if (expVal !== actVal) begin
      errCount++;
      $display("Fail %s %s: expected 0x%0h, actual 0x%0h", testName, what, expVal, actVal);
    end
  endtask

  task automatic reportError(input string msg);
    errCount++;
    $display("Error in %s: %s", testName, msg);
  endtask

  // about half the sources wait on a tag that is still pending
  task automatic pickSource(output rsPkg::srcT s);
    s.value = $urandom;
    s.tag = 6'($urandom);
    s.rdy = 1'b1;
    if (pendTag.size() > 0 && $urandom_range(1) == 1) begin
      s.tag = pendTag[$urandom_range(pendTag.size() - 1)];
      s.rdy = 1'b0;
    end
  endtask

  task automatic wakeModel(input rsPkg::bcastT b);
    for (int i = 0; i < presented; i++) begin
      if (mState[i] == 1 && !mDisp[i].srcA.rdy && mDisp[i].srcA.tag == b.tag) begin
        mDisp[i].srcA = '{tag: b.tag, rdy: 1'b1, value: b.value};
        mReadyCyc[i] = cyc;
      end
      if (mState[i] == 1 && !mDisp[i].srcB.rdy && mDisp[i].srcB.tag == b.tag) begin
        mDisp[i].srcB = '{tag: b.tag, rdy: 1'b1, value: b.value};
        mReadyCyc[i] = cyc;
      end
    end
  endtask

  // issue seen here was registered at the edge that closed the previous cycle
  task automatic observe();
    int ii;
    for (int p = 0; p < rsPkg::PortCount; p++) begin
      ii = int'(issue[p].ii);
      if (!issue[p].vld) continue;
      if (pause[p]) reportError($sformatf("port %0d issued right after a paused cycle", p));
      if (ii >= presented || mState[ii] != 1) begin
        reportError($sformatf("port %0d issued index %0d, which was not waiting", p, ii));
        continue;
      end
      if (!mDisp[ii].srcA.rdy || !mDisp[ii].srcB.rdy || cyc < mReadyCyc[ii] + 2) begin
        reportError($sformatf("index %0d issued before its operands were ready", ii));
      end
      checkVal("port", mDisp[ii].port, p);
      checkVal("opcode", mDisp[ii].op, issue[p].op);
      checkVal("dest", mDisp[ii].dest, issue[p].dest);
      checkVal("operand A", mDisp[ii].srcA.value, issue[p].dataA);
      checkVal("operand B", mDisp[ii].srcB.value, issue[p].dataB);
      mState[ii] = 2;
      inFlight--;
      issuedCnt++;
    end
    checkVal("doStall", inFlight == rsPkg::EntryCount, doStall);
    sawStall = sawStall | doStall;
  endtask

  task automatic drive();
    rsPkg::dispatchT d;
    rsPkg::bcastT b;
    int nb;
    d = '0;
    for (int p = 0; p < rsPkg::PortCount; p++) begin
      pause[p] = $urandom_range(99) < pauseRate;
    end
    if (presented < dispLimit && pendTag.size() < MaxPending &&
        $urandom_range(99) < dispRate) begin
      pickSource(d.srcA);
      pickSource(d.srcB);
      d.vld = 1'b1;
      d.dest = nextTag;
      d.op = 8'($urandom);
      d.ii = 10'(presented);
      d.port = 1'($urandom);
      mDisp[presented] = d;
      mReadyCyc[presented] = cyc;
      mState[presented] = (inFlight == rsPkg::EntryCount) ? 3 : 1;
      if (inFlight < rsPkg::EntryCount) begin
        pendTag.push_back(nextTag);
        nextTag++;
        inFlight++;
      end
      presented++;
    end
    dispatch = d;
    // oldest pending tags come back first and at most one per bus
    nb = $urandom_range(rsPkg::BcastCount);
    for (int i = 0; i < rsPkg::BcastCount; i++) begin
      b = '0;
      if (i < nb && pendTag.size() > 0) begin
        b.vld = 1'b1;
        b.tag = pendTag.pop_front();
        b.value = $urandom;
        wakeModel(b);
      end
      bcast[i] = b;
    end
  endtask

  task automatic stepCycle();
    @(negedge clk);
    cyc++;
    observe();
    drive();
  endtask

  // nDisp of zero keeps stepping until the station has drained
  task automatic runPhase(input string name, input int dRate, input int pRate,
                          input int nDisp, input bit expectStall);
    int errBefore;
    errBefore = errCount;
    testName = name;
    testCount++;
    dispRate = dRate;
    pauseRate = pRate;
    dispLimit = presented + nDisp;
    sawStall = 1'b0;
    while (presented < dispLimit || (nDisp == 0 && inFlight > 0)) begin
      stepCycle();
    end
    repeat (2) stepCycle();
    if (expectStall) checkVal("stall reached", 1, sawStall);
    $display("test %s done at cycle %0d, %0d errors", name, cyc, errCount - errBefore);
  endtask

  initial begin
    void'($urandom(32'hfe0667b0));
    rstN = 1'b0;
    dispatch = '0;
    bcast = '0;
    pause = '0;
    nextTag = '0;
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    testName = "reset";
    testCount++;
    checkVal("issue 0 valid", 0, issue[0].vld);
    checkVal("issue 1 valid", 0, issue[1].vld);
    checkVal("doStall", 0, doStall);
    $display("test reset done, %0d errors", errCount);
    runPhase("random traffic", 70, 25, RandDisp, 1'b0);
    runPhase("stall burst", 100, 100, BurstDisp, 1'b1);
    runPhase("drain", 0, 10, 0, 1'b0);
    $display("%0d tests, %0d checks, %0d errors, %0d of %0d dispatches issued",
             testCount, checkCount, errCount, issuedCnt, presented);
    if (errCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
